/* mul_ucode_pkg.sv */
`default_nettype none

package mul_ucode_pkg;

  localparam int UPC_W = 5;                  // 32 rom lines max

  localparam logic [3:0] SCRATCH_ACC = 4'd14; // product accumulator
  localparam logic [3:0] SCRATCH_CNT = 4'd15; // loop counter

  // macro opcodes, multiply codes fixed by the microcode rom encodings
  typedef enum logic [6:0] {
    OP_MOVI  = 7'b0000001,
    OP_ADD   = 7'b0000010,
    OP_SUB   = 7'b0000011,
    OP_MULI  = 7'b0010000,
    OP_MULSI = 7'b0011000,
    OP_MULR  = 7'b0110000,
    OP_MULSR = 7'b0111000
  } macro_op_e;

  typedef struct packed {
    logic [3:0]  src2;
    logic [12:0] pad;
  } reg_fields_t;

  typedef struct packed {
    logic        pad;
    logic [15:0] imm;
  } imm_fields_t;

  // low 17 bits hold either src2 or the immediate
  typedef union packed {
    reg_fields_t r;
    imm_fields_t i;
  } macro_operand_u;

  typedef struct packed {
    macro_op_e      opcode;
    logic [3:0]     dest;
    logic [3:0]     src1;
    macro_operand_u opnd;
  } macro_instr_t;

  // routine index and entry line in the rom
  localparam logic [3:0] RT_MOV = 4'd0;
  localparam logic [3:0] RT_ADD = 4'd1;
  localparam logic [3:0] RT_SUB = 4'd2;
  localparam logic [3:0] RT_MUL = 4'd3;  // all four multiplies share it

  localparam logic [UPC_W-1:0] ENT_MOV = 5'd0;
  localparam logic [UPC_W-1:0] ENT_ADD = 5'd1;
  localparam logic [UPC_W-1:0] ENT_SUB = 5'd2;
  localparam logic [UPC_W-1:0] ENT_MUL = 5'd3;

  typedef struct packed {
    logic [3:0]  routine;
    logic [3:0]  dest;
    logic [3:0]  src1;
    logic [3:0]  src2;
    logic [15:0] imm;
    logic        use_imm;    // multiplier from imm instead of src2
    logic        is_signed;
    logic        sets_flags;
  } dispatch_t;

  typedef enum logic [3:0] {
    UOP_NOP, UOP_MOVI, UOP_MOVR, UOP_ABS, UOP_ADD, UOP_SUB,
    UOP_CLR, UOP_TSTZ, UOP_BZ, UOP_BR, UOP_WB
  } uop_op_e;

  typedef struct packed {
    uop_op_e     op;
    logic [3:0]  dest;
    logic [3:0]  src_a;
    logic [3:0]  src_b;
    logic [15:0] imm;     // nonzero imm replaces src_b on add and sub
    logic signed [4:0] offset; // relative to upc
    logic        last;
    logic        arch;
    logic        flag_en;
  } uop_t;

  typedef struct packed {
    logic z;
    logic n;
  } flags_t;

  typedef struct packed {
    logic [3:0]  dest;
    logic [15:0] value;
    flags_t      flags;
  } retire_t;

  function automatic logic [UPC_W-1:0] routine_entry(input logic [3:0] routine);
    case (routine)
      RT_ADD:  return ENT_ADD;
      RT_SUB:  return ENT_SUB;
      RT_MUL:  return ENT_MUL;
      default: return ENT_MOV;
    endcase
  endfunction

endpackage

`default_nettype wire

/* macro_decoder.sv */
`default_nettype none

module macro_decoder
  import mul_ucode_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   arst_n,
  input  wire logic   instr_valid,
  input  macro_instr_t instr,
  input  wire logic   busy,
  output logic        disp_valid,
  output dispatch_t   disp
);

  dispatch_t dec;      // combinational decode of instr
  logic      known;    // opcode is one we execute
  logic      accept;

  // strobes while busy are simply lost
  assign accept = instr_valid & ~busy & known;

  always_comb begin
    dec            = '0;
    known          = 1'b1;
    dec.dest       = instr.dest;
    dec.src1       = instr.src1;
    dec.src2       = instr.opnd.r.src2;
    dec.imm        = instr.opnd.i.imm;  // same bits as src2, both kept
    case (instr.opcode)
      OP_MOVI: begin
        dec.routine    = RT_MOV;
        dec.use_imm    = 1'b1;
        dec.sets_flags = 1'b1;
      end
      OP_ADD: begin
        dec.routine    = RT_ADD;
        dec.sets_flags = 1'b1;
      end
      OP_SUB: begin
        dec.routine    = RT_SUB;
        dec.sets_flags = 1'b1;
      end
      OP_MULI, OP_MULR: begin           // unsigned mul leaves flags alone
        dec.routine = RT_MUL;
        dec.use_imm = (instr.opcode == OP_MULI);
      end
      OP_MULSI, OP_MULSR: begin
        dec.routine    = RT_MUL;
        dec.use_imm    = (instr.opcode == OP_MULSI);
        dec.is_signed  = 1'b1;
        dec.sets_flags = 1'b1;
      end
      default: known = 1'b0;            // unknown opcode, dropped
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      disp_valid <= 1'b0;
    end else begin
      disp_valid <= accept;             // one cycle after instr_valid
    end
  end

  // payload only loads on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      disp <= dec;
    end
  end

endmodule

`default_nettype wire

/* ucode_sequencer.sv */
`default_nettype none

module ucode_sequencer
  import mul_ucode_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                disp_valid,
  input  dispatch_t                disp,
  input  uop_t                     uop,
  input  wire logic                branch_taken,
  input  wire logic signed [4:0]   branch_offset,
  output logic                     busy,
  output logic [UPC_W-1:0]         upc,
  output dispatch_t                cur_disp,
  output logic                     uop_valid
);

  logic run_q;    // routine in flight
  logic done_q;   // cycle the retire port shows result_valid

  // busy covers the decode cycle, the routine and the result cycle
  assign busy      = disp_valid | run_q | done_q;
  assign uop_valid = run_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      upc    <= '0;
    end else begin
      done_q <= run_q & uop.last;
      if (run_q) begin
        if (uop.last) begin
          run_q <= 1'b0;                                   // routine retired
        end else if (branch_taken) begin
          upc <= upc + UPC_W'(branch_offset);              // exec decided
        end else begin
          upc <= upc + 5'd1;
        end
      end else if (disp_valid) begin
        run_q <= 1'b1;
        upc   <= routine_entry(disp.routine);              // first line
      end
    end
  end

  // operands stay put for the whole routine
  always_ff @(posedge clk) begin
    if (disp_valid && !run_q) begin
      cur_disp <= disp;
    end
  end

endmodule

`default_nettype wire

/* ucode_rom.sv */
`default_nettype none

module ucode_rom
  import mul_ucode_pkg::*;
(
  input  wire logic [UPC_W-1:0] upc,
  input  dispatch_t             cur_disp,
  output uop_t                  uop
);

  // multiply routine layout
  localparam logic [UPC_W-1:0] L_LOAD = ENT_MUL;          // counter <- multiplier
  localparam logic [UPC_W-1:0] L_ABS  = ENT_MUL + 5'd1;
  localparam logic [UPC_W-1:0] L_CLR  = ENT_MUL + 5'd2;
  localparam logic [UPC_W-1:0] L_TSTZ = ENT_MUL + 5'd3;   // loop head
  localparam logic [UPC_W-1:0] L_BZ   = ENT_MUL + 5'd4;
  localparam logic [UPC_W-1:0] L_ACC  = ENT_MUL + 5'd5;
  localparam logic [UPC_W-1:0] L_DEC  = ENT_MUL + 5'd6;
  localparam logic [UPC_W-1:0] L_BR   = ENT_MUL + 5'd7;
  localparam logic [UPC_W-1:0] L_WB   = ENT_MUL + 5'd8;   // exit

  localparam logic signed [4:0] OFS_EXIT = 5'(L_WB - L_BZ);   // forward
  localparam logic signed [4:0] OFS_LOOP = 5'(L_TSTZ - L_BR); // backward

  always_comb begin
    uop = '0;                              // nop, no write
    case (upc)
      ENT_MOV: begin                       // dest <- imm
        uop.op   = UOP_MOVI;
        uop.dest = cur_disp.dest;
        uop.imm  = cur_disp.imm;
        uop.last = 1'b1;
        uop.arch = 1'b1;
        uop.flag_en = cur_disp.sets_flags;
      end
      ENT_ADD, ENT_SUB: begin              // dest <- src1 +/- src2
        uop.op    = (upc == ENT_ADD) ? UOP_ADD : UOP_SUB;
        uop.dest  = cur_disp.dest;
        uop.src_a = cur_disp.src1;
        uop.src_b = cur_disp.src2;
        uop.last  = 1'b1;
        uop.arch  = 1'b1;
        uop.flag_en = cur_disp.sets_flags;
      end
      L_LOAD: begin
        uop.op    = cur_disp.use_imm ? UOP_MOVI : UOP_MOVR;
        uop.dest  = SCRATCH_CNT;
        uop.src_a = cur_disp.src2;         // ignored for movi
        uop.imm   = cur_disp.imm;
      end
      L_ABS: begin                         // magnitude, sign into latch
        uop.op    = UOP_ABS;
        uop.dest  = SCRATCH_CNT;
        uop.src_a = SCRATCH_CNT;
      end
      L_CLR: begin
        uop.op   = UOP_CLR;
        uop.dest = SCRATCH_ACC;
      end
      L_TSTZ: begin
        uop.op    = UOP_TSTZ;
        uop.src_a = SCRATCH_CNT;
      end
      L_BZ: begin
        uop.op     = UOP_BZ;
        uop.offset = OFS_EXIT;
      end
      L_ACC: begin                         // acc += multiplicand
        uop.op    = UOP_ADD;
        uop.dest  = SCRATCH_ACC;
        uop.src_a = SCRATCH_ACC;
        uop.src_b = cur_disp.src1;
      end
      L_DEC: begin                         // cnt -= 1, imm as operand b
        uop.op    = UOP_SUB;
        uop.dest  = SCRATCH_CNT;
        uop.src_a = SCRATCH_CNT;
        uop.imm   = 16'd1;
      end
      L_BR: begin
        uop.op     = UOP_BR;
        uop.offset = OFS_LOOP;
      end
      L_WB: begin
        uop.op      = UOP_WB;
        uop.dest    = cur_disp.dest;
        uop.src_a   = SCRATCH_ACC;
        uop.last    = 1'b1;
        uop.arch    = 1'b1;
        uop.flag_en = cur_disp.sets_flags; // muls only
      end
      default: uop.last = 1'b1;            // stray upc ends the routine
    endcase
  end

endmodule

`default_nettype wire

/* uop_exec.sv */
`default_nettype none

module uop_exec
  import mul_ucode_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          arst_n,
  input  wire logic          uop_valid,
  input  uop_t               uop,
  input  wire logic          is_signed,
  output logic               branch_taken,
  output logic signed [4:0]  branch_offset,
  output logic               wb_valid,
  output retire_t            wb
);

  logic [15:0] regs [16];        // r14/r15 are microcode scratch
  flags_t      flags_q;          // architectural z/n
  logic        loop_zero_q;      // tstz result, kept apart from flags_q
  logic        sign_q;           // multiplier was negative

  logic [15:0] a_val;
  logic [15:0] b_val;
  logic [15:0] res;
  logic        we;               // op writes uop.dest
  logic        taken;
  logic        sign_nxt;
  flags_t      new_flags;

  always_comb begin
    a_val    = regs[uop.src_a];
    b_val    = (uop.imm != 16'd0) ? uop.imm : regs[uop.src_b];
    res      = a_val;
    we       = 1'b0;
    taken    = 1'b0;
    sign_nxt = sign_q;
    case (uop.op)
      UOP_MOVI: begin res = uop.imm;      we = 1'b1; end
      UOP_MOVR: begin res = a_val;        we = 1'b1; end
      UOP_ADD:  begin res = a_val + b_val; we = 1'b1; end
      UOP_SUB:  begin res = a_val - b_val; we = 1'b1; end
      UOP_CLR:  begin res = 16'd0;        we = 1'b1; end
      UOP_ABS: begin
        sign_nxt = is_signed & a_val[15];              // unsigned keeps raw count
        res      = sign_nxt ? (16'd0 - a_val) : a_val;
        we       = 1'b1;
      end
      UOP_WB: begin
        res = (sign_q & is_signed) ? (16'd0 - a_val) : a_val;
        we  = 1'b1;
      end
      UOP_BZ:  taken = loop_zero_q;
      UOP_BR:  taken = 1'b1;
      default: ;                                       // nop and tstz
    endcase
    new_flags.z = (res == 16'd0);
    new_flags.n = res[15];
  end

  assign branch_taken  = uop_valid & taken;
  assign branch_offset = uop.offset;

  // retire record goes out the same cycle as the last micro-op
  assign wb_valid    = uop_valid & uop.last & uop.arch;
  assign wb.dest     = uop.dest;
  assign wb.value    = res;
  assign wb.flags    = uop.flag_en ? new_flags : flags_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'd0;
      end
      flags_q     <= '0;
      loop_zero_q <= 1'b0;
      sign_q      <= 1'b0;
    end else if (uop_valid) begin
      if (we) begin
        regs[uop.dest] <= res;
      end
      if (uop.op == UOP_TSTZ) begin
        loop_zero_q <= (a_val == 16'd0);               // read by next bz
      end
      sign_q <= sign_nxt;
      if (uop.last && uop.flag_en) begin
        flags_q <= new_flags;
      end
    end
  end

endmodule

`default_nettype wire

/* retire_port.sv */
`default_nettype none

module retire_port
  import mul_ucode_pkg::*;
#(
  parameter int RETIRE_CNT_W = 8
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  wb_valid,
  input  retire_t                    wb,
  output logic                       result_valid,
  output retire_t                    result,
  output logic [RETIRE_CNT_W-1:0]    retired_count
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid  <= 1'b0;
      retired_count <= '0;
    end else begin
      result_valid <= wb_valid;                 // one cycle behind exec
      if (wb_valid) begin
        retired_count <= retired_count + 1'b1;  // wraps at width
      end
    end
  end

  // record held until the next retirement
  always_ff @(posedge clk) begin
    if (wb_valid) begin
      result <= wb;
    end
  end

endmodule

`default_nettype wire

/* mul_core_top.sv */
`default_nettype none

module mul_core_top
  import mul_ucode_pkg::*;
#(
  parameter int RETIRE_CNT_W = 8
) (
  input  wire logic                clk,
  input  wire logic                arst_n,
  input  wire logic                instr_valid,
  input  macro_instr_t             instr,
  output logic                     busy,
  output logic                     result_valid,
  output retire_t                  result,
  output logic [RETIRE_CNT_W-1:0]  retired_count
);

  logic              disp_valid;
  dispatch_t         disp;
  dispatch_t         cur_disp;        // operands of the running routine
  logic [UPC_W-1:0]  upc;
  uop_t              uop;
  logic              uop_valid;
  logic              branch_taken;
  logic signed [4:0] branch_offset;
  logic              wb_valid;
  retire_t           wb;

  macro_decoder u_dec (
    .clk, .arst_n, .instr_valid, .instr, .busy, .disp_valid, .disp
  );

  ucode_sequencer u_seq (
    .clk, .arst_n, .disp_valid, .disp, .uop, .branch_taken, .branch_offset,
    .busy, .upc, .cur_disp, .uop_valid
  );

  ucode_rom u_rom (.upc, .cur_disp, .uop);  // combinational lookup

  uop_exec u_exec (
    .clk, .arst_n, .uop_valid, .uop, .is_signed(cur_disp.is_signed),
    .branch_taken, .branch_offset, .wb_valid, .wb
  );

  retire_port #(.RETIRE_CNT_W(RETIRE_CNT_W)) u_ret (
    .clk, .arst_n, .wb_valid, .wb, .result_valid, .result, .retired_count
  );

endmodule

`default_nettype wire

/* tb_mul_core.sv */
`default_nettype none

module tb_mul_core
  import mul_ucode_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CNT_W      = 8;
  localparam int WAIT_LIMIT = 400;    // one muls of magnitude 63 is ~330 cycles
  localparam int MAX_CYCLES = 20000;  // ~66 instructions, about 20 of them multiplies

  logic               clk;
  logic               arst_n;
  logic               instr_valid;
  macro_instr_t       instr;
  logic               busy;
  logic               result_valid;
  retire_t            result;
  logic [CNT_W-1:0]   retired_count;

  logic [15:0] model_regs [16];  // only r0..r13 are ever compared
  flags_t      model_flags;
  int          n_issued;
  int          cycle_cnt = 0;
  integer      seed = 47490;

  mul_core_top #(.RETIRE_CNT_W(CNT_W)) uut (
    .clk, .arst_n, .instr_valid, .instr, .busy, .result_valid, .result, .retired_count
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run aborted");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else abort_run($sformatf("MISMATCH %s %s: expected %0h actual %0h", name, what, exp, act));
  endtask

  function automatic macro_instr_t mk_imm(input macro_op_e op, input int d, input int s1,
                                          input logic [15:0] imm);
    macro_instr_t i;
    i            = '0;
    i.opcode     = op;
    i.dest       = d[3:0];
    i.src1       = s1[3:0];
    i.opnd.i.imm = imm;
    return i;
  endfunction

  function automatic macro_instr_t mk_reg(input macro_op_e op, input int d, input int s1,
                                          input int s2);
    macro_instr_t i;
    i             = '0;
    i.opcode      = op;
    i.dest        = d[3:0];
    i.src1        = s1[3:0];
    i.opnd.r.src2 = s2[3:0];
    return i;
  endfunction

  function automatic logic [15:0] rand16();
    return $random(seed);
  endfunction

  function automatic int rand_reg();  // r0..r12, r13 stays the zero register
    return $unsigned($random(seed)) % 13;
  endfunction

  function automatic int rand_mag();
    return $random(seed) & 63;
  endfunction

  // expected value and flags straight from the macro semantics
  task automatic predict(input macro_instr_t ins, output logic [15:0] v, output flags_t fl);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] m;
    int          prod;
    a  = model_regs[ins.src1];
    b  = model_regs[ins.opnd.r.src2];
    fl = model_flags;
    v  = '0;
    case (ins.opcode)
      OP_MOVI: v = ins.opnd.i.imm;
      OP_ADD:  v = a + b;
      OP_SUB:  v = a - b;
      OP_MULI: v = a * ins.opnd.i.imm;   // low 16 bits
      OP_MULR: v = a * b;
      OP_MULSI, OP_MULSR: begin
        m    = (ins.opcode == OP_MULSI) ? ins.opnd.i.imm : b;
        prod = int'(a) * int'($signed(m));
        v    = prod[15:0];
      end
      default: abort_run("testbench built an instruction with an unknown opcode");
    endcase
    if (ins.opcode != OP_MULI && ins.opcode != OP_MULR) begin  // unsigned mul keeps flags
      fl.z = (v == 16'd0);
      fl.n = v[15];
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("core stayed busy and never went idle");
      @(negedge clk);
    end
  endtask

  task automatic send(input macro_instr_t ins);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= ins;
    @(posedge clk);
    instr_valid <= 1'b0;   // single-cycle strobe
  endtask

  task automatic check_retire(input string name, input macro_instr_t ins,
                              input logic [15:0] v, input flags_t fl);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!result_valid) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run($sformatf("no result_valid for %s", name));
      @(negedge clk);
    end
    n_issued++;
    check_val(name, "dest", ins.dest, result.dest);
    check_val(name, "value", v, result.value);
    check_val(name, "flags", fl, result.flags);
    check_val(name, "retired_count", n_issued[CNT_W-1:0], retired_count);
    model_regs[ins.dest] = v;
    model_flags          = fl;
  endtask

  task automatic run_instr(input string name, input macro_instr_t ins);
    logic [15:0] v;
    flags_t      fl;
    predict(ins, v, fl);
    wait_idle();
    send(ins);
    check_retire(name, ins, v, fl);
  endtask

  initial begin
    logic [15:0] v;
    flags_t      fl;
    logic [15:0] a;
    int          m;
    macro_instr_t ins;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    n_issued    = 0;
    model_flags = '0;
    for (int r = 0; r < 16; r++) model_regs[r] = 16'd0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    repeat (5) begin  // quiet after reset
      @(negedge clk);
      check_val("reset", "result_valid", 0, result_valid);
      check_val("reset", "busy", 0, busy);
      check_val("reset", "retired_count", 0, retired_count);
    end

    for (int r = 0; r < 13; r++) run_instr("mov_imm", mk_imm(OP_MOVI, r, 0, rand16()));
    run_instr("add_reg", mk_reg(OP_ADD, 0, 1, 2));
    run_instr("sub_reg", mk_reg(OP_SUB, 4, 5, 6));
    run_instr("sub_zero", mk_reg(OP_SUB, 7, 7, 7));    // z set
    run_instr("sub_neg", mk_reg(OP_SUB, 8, 13, 9));    // 0 - r9

    run_instr("mov_neg", mk_imm(OP_MOVI, 12, 0, 16'h8000));  // n set before unsigned mul
    for (int k = 0; k < 5; k++) begin
      m = (k < 2) ? k : rand_mag();
      run_instr("mul_imm", mk_imm(OP_MULI, rand_reg(), rand_reg(), 16'(m)));
    end
    for (int k = 0; k < 5; k++) begin
      m = (k < 2) ? k : rand_mag();
      run_instr("mul_reg_setup", mk_imm(OP_MOVI, 11, 0, 16'(m)));
      run_instr("mul_reg", mk_reg(OP_MULR, rand_reg(), rand_reg(), 11));
    end

    for (int k = 0; k < 4; k++) begin  // k[0] negative multiplier, k[1] negative multiplicand
      m     = 1 + rand_mag() % 63;
      m     = k[0] ? -m : m;
      a     = rand16();
      a[15] = k[1];
      run_instr("muls_setup", mk_imm(OP_MOVI, 9, 0, a));
      run_instr("muls_imm", mk_imm(OP_MULSI, rand_reg(), 9, 16'(m)));
      run_instr("muls_setup", mk_imm(OP_MOVI, 10, 0, 16'(m)));
      run_instr("muls_reg", mk_reg(OP_MULSR, rand_reg(), 9, 10));
    end

    for (int r = 0; r < 14; r++) run_instr("readback", mk_reg(OP_ADD, r, r, 13));

    // strobe during a running multiply must vanish
    run_instr("drop_setup", mk_imm(OP_MOVI, 11, 0, 16'd40));
    ins = mk_reg(OP_MULR, 6, 7, 11);
    predict(ins, v, fl);
    wait_idle();
    send(ins);
    @(negedge clk);
    check_val("busy_drop", "busy", 1, busy);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= mk_imm(OP_MOVI, 5, 0, ~model_regs[5]);
    @(posedge clk);
    instr_valid <= 1'b0;
    check_retire("busy_drop_mul", ins, v, fl);
    repeat (20) begin
      @(negedge clk);
      check_val("busy_drop", "busy", 0, busy);
      check_val("busy_drop", "result_valid", 0, result_valid);
      check_val("busy_drop", "retired_count", n_issued[CNT_W-1:0], retired_count);
    end
    run_instr("busy_drop_readback", mk_reg(OP_ADD, 5, 5, 13));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
mul_ucode_pkg.sv
macro_decoder.sv
ucode_sequencer.sv
ucode_rom.sv
uop_exec.sv
retire_port.sv
mul_core_top.sv
tb_mul_core.sv
